// ==== sources.f ====
spi_pkg.sv
spi_frame_if.sv
spi_clk_gen.sv
spi_shifter.sv
spi_ctrl.sv
spi_master_top.sv
spi_dev_model.sv
tb_spi_master.sv

// ==== Bender.yml ====
package:
  name: spi_master

sources:
  - files:
      - spi_pkg.sv
      - spi_frame_if.sv
      - spi_clk_gen.sv
      - spi_shifter.sv
      - spi_ctrl.sv
      - spi_master_top.sv
  - target: test
    files:
      - spi_dev_model.sv
      - tb_spi_master.sv

// ==== tb_spi_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_spi_master;
  import spi_pkg::*;

  localparam int CLK_DIV     = 4;
  localparam int NUM_TESTS   = 16;
  localparam int CYCLE_LIMIT = NUM_TESTS * (26 * CLK_DIV + 3) + 200;

  logic                  clk;
  logic                  rst_n;
  logic [CMD_WIDTH-1:0]  cmd_in;
  logic                  cmd_vld;
  logic                  cmd_rdy;
  logic                  sclk;
  logic                  cs;
  logic                  mosi;
  logic                  miso;
  logic                  read_vld;
  logic [READ_WIDTH-1:0] read_data;
  int                    frame_count;
  logic [3:0]            last_rises;
  logic                  sclk_while_cs_high;

  string                 tbl_name [NUM_TESTS];
  logic [CMD_WIDTH-1:0]  tbl_cmd [NUM_TESTS];
  logic [READ_WIDTH-1:0] tbl_exp [NUM_TESTS];
  bit                    tbl_bp [NUM_TESTS];     // Present this command while the previous one runs.
  logic [7:0]            mirror [8];
  int                    n_entries;
  int                    errors;
  int                    failed_tests;
  int                    cycles;
  integer                seed;

  spi_master_top #(
    .CLK_DIV (CLK_DIV)
  ) dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  spi_dev_model dev (
    .rst_n              (rst_n),
    .sclk               (sclk),
    .cs                 (cs),
    .mosi               (mosi),
    .miso               (miso),
    .frame_count        (frame_count),
    .last_rises         (last_rises),
    .sclk_while_cs_high (sclk_while_cs_high)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Expected read values come from the mirror as the table is built.
  task add_entry(input string name, input logic [CMD_WIDTH-1:0] cmd, input bit bp);
    logic [ADDR_WIDTH-1:0] addr;
    begin
      addr                = cmd[ADDR_MSB:ADDR_LSB];
      tbl_name[n_entries] = name;
      tbl_cmd[n_entries]  = cmd;
      tbl_bp[n_entries]   = bp;
      if (cmd[RW_BIT])
      begin
        mirror[addr]       = cmd[READ_WIDTH-1:0];
        tbl_exp[n_entries] = '0;
      end
      else
        tbl_exp[n_entries] = mirror[addr];
      n_entries++;
    end
  endtask

  task report_mismatch(input string name, input string what, input logic [31:0] expected,
                       input logic [31:0] actual);
    begin
      $display("CHECK FAILED %s %s expected %0h actual %0h", name, what, expected, actual);
      errors++;
    end
  endtask

  initial
  begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
    $display("FAIL: see errors above");
    $finish;
  end

  initial
  begin
    logic [READ_WIDTH-1:0] rd_val;
    logic [CMD_WIDTH-1:0]  r_cmd;
    integer                r;
    int                    rd_cnt;
    int                    errs_before;
    bit                    presented;
    rst_n        = 1'b0;
    cmd_in       = '0;
    cmd_vld      = 1'b0;
    errors       = 0;
    failed_tests = 0;
    n_entries    = 0;
    presented    = 1'b0;
    seed         = 32'h45bc_4f02;
    for (int a = 0; a < 8; a++)
      mirror[a] = 8'(a * 8'h11);

    add_entry("rd3_untouched", {1'b0, 3'd3, 8'h00}, 1'b0);
    add_entry("wr5", {1'b1, 3'd5, 8'ha5}, 1'b0);
    add_entry("rd5_readback", {1'b0, 3'd5, 8'h00}, 1'b0);
    add_entry("wr0_held", {1'b1, 3'd0, 8'h3c}, 1'b1);
    add_entry("rd0_held", {1'b0, 3'd0, 8'h00}, 1'b1);
    add_entry("rd7_untouched", {1'b0, 3'd7, 8'h00}, 1'b0);
    for (int k = 0; k < NUM_TESTS - 6; k++)
    begin
      r = $random(seed);
      if (r[0])
        r_cmd = {1'b1, r[3:1], r[11:4]};
      else
        r_cmd = {1'b0, r[3:1], 8'h00};
      add_entry($sformatf("rand_%0d", k), r_cmd, r[12]);
    end

    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    errs_before = errors;
    if (cs !== 1'b1)
      report_mismatch("reset_state", "cs", 1, cs);
    if (sclk !== 1'b0)
      report_mismatch("reset_state", "sclk", 0, sclk);
    if (mosi !== 1'b0)
      report_mismatch("reset_state", "mosi", 0, mosi);
    if (read_vld !== 1'b0)
      report_mismatch("reset_state", "read_vld", 0, read_vld);
    if (cmd_rdy !== 1'b1)
      report_mismatch("reset_state", "cmd_rdy", 1, cmd_rdy);
    if (errors == errs_before)
      $display("%-16s ok", "reset_state");
    else
    begin
      $display("%-16s failed", "reset_state");
      failed_tests++;
    end

    for (int i = 0; i < NUM_TESTS; i++)
    begin
      errs_before = errors;
      if (!presented)
      begin
        @(posedge clk);
        cmd_in  <= tbl_cmd[i];
        cmd_vld <= 1'b1;
        @(negedge clk);
      end
      while (!cmd_rdy)
        @(negedge clk);
      @(posedge clk);                                     // The DUT takes the command here.
      if (i + 1 < NUM_TESTS && tbl_bp[i + 1])
      begin
        cmd_in    <= tbl_cmd[i + 1];
        presented  = 1'b1;
      end
      else
      begin
        cmd_vld   <= 1'b0;
        presented  = 1'b0;
      end
      rd_cnt = 0;
      do
      begin
        @(negedge clk);
        if (read_vld === 1'b1)
        begin
          rd_cnt++;
          rd_val = read_data;
        end
      end
      while (!cmd_rdy);

      if (tbl_cmd[i][RW_BIT])
      begin
        if (rd_cnt != 0)
          report_mismatch(tbl_name[i], "read_vld pulses", 0, rd_cnt);
      end
      else if (rd_cnt != 1)
        report_mismatch(tbl_name[i], "read_vld pulses", 1, rd_cnt);
      else if (rd_val !== tbl_exp[i])
        report_mismatch(tbl_name[i], "read_data", tbl_exp[i], rd_val);
      if (frame_count != i + 1)
        report_mismatch(tbl_name[i], "frame_count", i + 1, frame_count);
      if (last_rises !== 4'd12)
        report_mismatch(tbl_name[i], "sclk rises", 12, last_rises);
      if (sclk_while_cs_high)
      begin
        $display("Error in %s: sclk was seen high while cs was high", tbl_name[i]);
        errors++;
      end
      if (errors == errs_before)
        $display("%-16s ok", tbl_name[i]);
      else
      begin
        $display("%-16s failed", tbl_name[i]);
        failed_tests++;
      end
    end

    if (frame_count != NUM_TESTS)
      report_mismatch("frame_total", "frame_count", NUM_TESTS, frame_count);
    $display("Summary: %0d tests, %0d failed, %0d check errors", NUM_TESTS + 1, failed_tests,
             errors);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

// ==== spi_dev_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_dev_model (
  input  logic       rst_n,
  input  logic       sclk,
  input  logic       cs,
  input  logic       mosi,
  output logic       miso,
  output int         frame_count,
  output logic [3:0] last_rises,                         // Rises seen in the latest frame.
  output logic       sclk_while_cs_high
);

  logic [7:0]  regs [8];
  logic [11:0] in_shift;
  logic [3:0]  rise_cnt;
  logic [7:0]  out_byte;

  // Cs falls while sclk idles low, which clears the bit counter for the new frame.
  always @(posedge sclk or negedge cs)
  begin
    if (!sclk)
    begin
      rise_cnt <= '0;
      in_shift <= '0;
    end
    else if (!cs)
    begin
      rise_cnt <= rise_cnt + 1'b1;
      in_shift <= {in_shift[10:0], mosi};                 // Mode 0 samples on the rise.
    end
  end

  always @(negedge sclk or negedge rst_n)
  begin
    if (!rst_n)
      out_byte <= '0;
    else if (!cs)
    begin
      // After the four header bits a read loads the addressed byte.
      if (rise_cnt == 4'd4 && !in_shift[3])
        out_byte <= regs[in_shift[2:0]];
      else
        out_byte <= {out_byte[6:0], 1'b0};
    end
  end

  assign miso = out_byte[7];

  always @(posedge cs or negedge rst_n)
  begin
    if (!rst_n)
    begin
      frame_count <= 0;
      last_rises  <= '0;
      for (int a = 0; a < 8; a++)
        regs[a] <= 8'(a * 8'h11);
    end
    else
    begin
      frame_count <= frame_count + 1;
      last_rises  <= rise_cnt;
      if (rise_cnt == 4'd12 && in_shift[11])
        regs[in_shift[10:8]] <= in_shift[7:0];            // Write commits at the end of the frame.
    end
  end

  always @(sclk or cs or rst_n)
  begin
    if (!rst_n)
      sclk_while_cs_high <= 1'b0;
    else if (sclk === 1'b1 && cs === 1'b1)
      sclk_while_cs_high <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== spi_master_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_master_top #(
  parameter int unsigned CLK_DIV = 4
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [spi_pkg::CMD_WIDTH-1:0]  cmd_in,
  input  logic                           cmd_vld,
  output logic                           cmd_rdy,
  output logic                           sclk,
  output logic                           cs,
  output logic                           mosi,
  input  logic                           miso,
  output logic                           read_vld,
  output logic [spi_pkg::READ_WIDTH-1:0] read_data
);

  logic run;
  logic toggle;
  logic half_tick;
  logic rise;
  logic fall;

  spi_frame_if frame_bus ();

  spi_ctrl #(
    .CLK_DIV (CLK_DIV)
  ) u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .cs        (cs),
    .run       (run),
    .half_tick (half_tick),
    .frame     (frame_bus.ctrl),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  spi_shifter u_shifter (
    .clk    (clk),
    .rst_n  (rst_n),
    .frame  (frame_bus.shift),
    .rise   (rise),
    .fall   (fall),
    .toggle (toggle),
    .mosi   (mosi),
    .miso   (miso)
  );

  spi_clk_gen #(
    .CLK_DIV (CLK_DIV)
  ) u_clk_gen (
    .clk       (clk),
    .rst_n     (rst_n),
    .run       (run),
    .toggle    (toggle),
    .half_tick (half_tick),
    .sclk      (sclk),
    .rise      (rise),
    .fall      (fall)
  );

endmodule

`default_nettype wire

// ==== spi_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_ctrl #(
  parameter int unsigned CLK_DIV = 4
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [spi_pkg::CMD_WIDTH-1:0]  cmd_in,
  input  logic                           cmd_vld,
  output logic                           cmd_rdy,
  output logic                           cs,
  output logic                           run,
  input  logic                           half_tick,
  spi_frame_if.ctrl                      frame,
  output logic                           read_vld,
  output logic [spi_pkg::READ_WIDTH-1:0] read_data
);
  import spi_pkg::*;

  // With the shortest divider the hold tick falls in the same cycle as done.
  localparam bit HOLD_ON_DONE = (CLK_DIV == 2);

  ctrl_state_t          state;
  logic [CMD_WIDTH-1:0] cmd_q;
  logic                 is_write_q;
  logic                 accept;

  assign accept  = cmd_vld && cmd_rdy;
  assign cmd_rdy = (state == ST_IDLE);

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cmd_q      <= cmd_in;
      is_write_q <= cmd_in[RW_BIT];
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= ST_IDLE;
      cs    <= 1'b1;
      run   <= 1'b0;
    end
    else
    begin
      case (state)
        ST_IDLE:
          if (accept)
          begin
            state <= ST_SETUP;
            cs    <= 1'b0;
            run   <= 1'b1;                                // Setup half-period starts counting.
          end
        ST_SETUP:
          if (frame.start)
            state <= ST_XFER;
        ST_XFER:
          if (frame.done)
          begin
            state <= ST_HOLD;
            if (HOLD_ON_DONE)
            begin
              cs  <= 1'b1;
              run <= 1'b0;
            end
          end
        ST_HOLD:
          // Cs goes high on the hold tick and the FSM moves on a cycle later.
          if (cs)
            state <= ST_DONE;
          else if (half_tick)
          begin
            cs  <= 1'b1;
            run <= 1'b0;
          end
        ST_DONE:
          state <= ST_IDLE;
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  assign frame.start    = (state == ST_SETUP) && half_tick && !frame.busy;
  assign frame.is_write = is_write_q;
  assign frame.cmd      = cmd_q;

  assign read_vld  = (state == ST_DONE) && !is_write_q;   // Single pulse, no back-pressure.
  assign read_data = frame.rx_data;

endmodule

`default_nettype wire

// ==== spi_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_shifter (
  input  logic              clk,
  input  logic              rst_n,
  spi_frame_if.shift        frame,
  input  logic              rise,
  input  logic              fall,
  output logic              toggle,
  output logic              mosi,
  input  logic              miso
);
  import spi_pkg::*;

  logic [CMD_WIDTH-1:0]  tx_shift;
  logic [READ_WIDTH-1:0] rx_shift;
  logic [3:0]            rise_cnt;
  logic                  busy_q;
  logic                  done_q;
  logic                  last_fall;
  logic                  read_phase;

  assign last_fall  = busy_q && fall && (rise_cnt == 4'(CMD_WIDTH));
  assign read_phase = !frame.is_write && (rise_cnt >= 4'(READ_HDR_BITS));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy_q   <= 1'b0;
      done_q   <= 1'b0;
      rise_cnt <= '0;
      tx_shift <= '0;
    end
    else
    begin
      done_q <= last_fall;
      if (frame.start)
      begin
        busy_q   <= 1'b1;
        rise_cnt <= '0;
        // Reads keep only the header so mosi stays low during the data phase.
        if (frame.is_write)
          tx_shift <= frame.cmd;
        else
          tx_shift <= {frame.cmd[RW_BIT], frame.cmd[ADDR_MSB:ADDR_LSB], {READ_WIDTH{1'b0}}};
      end
      else if (busy_q)
      begin
        if (rise)
          rise_cnt <= rise_cnt + 1'b1;
        if (fall)
          tx_shift <= {tx_shift[CMD_WIDTH-2:0], 1'b0};    // Next bit appears after the fall.
        if (last_fall)
          busy_q <= 1'b0;
      end
    end
  end

  // Miso is taken one clk after the rising edge, well inside the slave's hold.
  always_ff @(posedge clk)
  begin
    if (busy_q && rise && read_phase)
      rx_shift <= {rx_shift[READ_WIDTH-2:0], miso};
  end

  assign mosi          = tx_shift[CMD_WIDTH-1];
  assign toggle        = busy_q;
  assign frame.busy    = busy_q;
  assign frame.done    = done_q;
  assign frame.rx_data = rx_shift;

endmodule

`default_nettype wire

// ==== spi_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_clk_gen #(
  parameter int unsigned CLK_DIV = 4
) (
  input  logic clk,
  input  logic rst_n,
  input  logic run,
  input  logic toggle,
  output logic half_tick,
  output logic sclk,
  output logic rise,
  output logic fall
);

  localparam int unsigned CNT_W = $clog2(CLK_DIV);

  logic [CNT_W-1:0] div_cnt;

  // The counter is held at zero while idle so each frame starts on a full half-period.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      div_cnt <= '0;
    else if (!run || half_tick)
      div_cnt <= '0;
    else
      div_cnt <= div_cnt + 1'b1;
  end

  assign half_tick = run && (div_cnt == CNT_W'(CLK_DIV - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sclk <= 1'b0;                                       // Mode 0 idles low.
      rise <= 1'b0;
      fall <= 1'b0;
    end
    else
    begin
      rise <= 1'b0;
      fall <= 1'b0;
      if (!toggle)
        sclk <= 1'b0;
      else if (half_tick)
      begin
        sclk <= ~sclk;
        rise <= ~sclk;                                    // Strobes line up with the new level.
        fall <= sclk;
      end
    end
  end

endmodule

`default_nettype wire

// ==== spi_frame_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface spi_frame_if;
  import spi_pkg::*;

  logic                  start;     // One cycle, only while busy is low.
  logic                  is_write;
  logic [CMD_WIDTH-1:0]  cmd;
  logic                  busy;
  logic                  done;      // One cycle after the last falling sclk edge.
  logic [READ_WIDTH-1:0] rx_data;

  modport ctrl (
    output start,
    output is_write,
    output cmd,
    input  busy,
    input  done,
    input  rx_data
  );

  modport shift (
    input  start,
    input  is_write,
    input  cmd,
    output busy,
    output done,
    output rx_data
  );

endinterface

`default_nettype wire

// ==== spi_pkg.sv ====
`default_nettype none

package spi_pkg;

  // Command word layout is {rw, addr[2:0], data[7:0]}.
  localparam int CMD_WIDTH  = 12;
  localparam int READ_WIDTH = 8;
  localparam int ADDR_WIDTH = 3;

  localparam int RW_BIT   = CMD_WIDTH - 1;                  // High selects a write.
  localparam int ADDR_LSB = READ_WIDTH;
  localparam int ADDR_MSB = ADDR_LSB + ADDR_WIDTH - 1;

  // A read sends only the rw flag and the address before turning the bus around.
  localparam int READ_HDR_BITS = 1 + ADDR_WIDTH;

  typedef enum logic [2:0] {
    ST_IDLE  = 3'd0,
    ST_SETUP = 3'd1,
    ST_XFER  = 3'd2,
    ST_HOLD  = 3'd3,
    ST_DONE  = 3'd4
  } ctrl_state_t;

endpackage

`default_nettype wire
